//--- filelist.f
rtl/cu_config_pkg.sv
rtl/graph_types_pkg.sv
rtl/edge_read_if.sv
rtl/sync_fifo.sv
rtl/sum_kernel_control.sv
rtl/sum_cu_top.sv
tb/sum_cu_assert.sv
tb/sum_cu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= sum_cu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/sum_cu_tb.sv
// Summing compute unit testbench
`timescale 1ns/1ns
`default_nettype none

module sum_cu_tb import cu_config_pkg::*; ();

	localparam int CLK_PERIOD      = 10;
	localparam int TB_CU_ID        = 5;
	// Cycles allowed for one awaited event
	localparam int EVENT_TIMEOUT   = 60;
	// Worst case edge total over all tests, a full input buffer included
	localparam int MAX_EDGES       = 4 + 5 * 8 + DEFAULT_EDGE_DEPTH + 12;
	localparam int CYCLES_PER_EDGE = 12;
	localparam int SLACK_CYCLES    = 400;
	localparam int WATCHDOG_NS     = (MAX_EDGES * CYCLES_PER_EDGE + SLACK_CYCLES) * CLK_PERIOD;
	localparam int REC_W           = VERTEX_ID_W + CU_ID_W + EDGE_DATA_W;

	logic                   clock = 1'b0;
	logic                   rstn;
	logic                   edge_push;
	logic [EDGE_DATA_W-1:0] edge_value;
	logic                   edge_full;
	logic                   job_valid;
	logic [VERTEX_ID_W-1:0] job_id;
	logic [DEGREE_W-1:0]    job_degree;
	logic                   enable;
	logic                   write_valid;
	logic [VERTEX_ID_W-1:0] write_index;
	logic [CU_ID_W-1:0]     write_cu_id;
	logic [EDGE_DATA_W-1:0] write_data;
	logic                   write_alfull;
	logic                   write_response;
	logic [EDGE_DATA_W-1:0] edge_count;
	logic [VERTEX_ID_W-1:0] response_count;

	// Bookkeeping
	logic [31:0]            rng_state = 32'd83968;
	logic [EDGE_DATA_W-1:0] stim_values[$];
	logic [REC_W-1:0]       rec_q[$];
	int                     error_count;
	int                     test_errors;
	int                     check_count;
	int                     test_count;
	int                     total_edges;
	int                     responses_sent;

	sum_cu_top #(
		.CU_ID      (TB_CU_ID),
		.EDGE_DEPTH (DEFAULT_EDGE_DEPTH),
		.WRITE_DEPTH(DEFAULT_WRITE_DEPTH)
	) i_dut (
		.clock         (clock),
		.rstn          (rstn),
		.edge_push     (edge_push),
		.edge_value    (edge_value),
		.edge_full     (edge_full),
		.job_valid     (job_valid),
		.job_id        (job_id),
		.job_degree    (job_degree),
		.enable        (enable),
		.write_valid   (write_valid),
		.write_index   (write_index),
		.write_cu_id   (write_cu_id),
		.write_data    (write_data),
		.write_alfull  (write_alfull),
		.write_response(write_response),
		.edge_count    (edge_count),
		.response_count(response_count)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// Collect write strobes mid-cycle
	always @(negedge clock) begin
		if (rstn && write_valid) begin
			rec_q.push_back({write_index, write_cu_id, write_data});
		end
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic fill_random_values(input int n);
		stim_values.delete();
		for (int i = 0; i < n; i++) begin
			rng_state = xorshift32(rng_state);
			stim_values.push_back(rng_state);
		end
	endtask

	// Reference sum wrapping at the data width
	function automatic logic [EDGE_DATA_W-1:0] model_sum();
		logic [EDGE_DATA_W-1:0] acc;
		acc = '0;
		foreach (stim_values[i]) begin
			acc = acc + stim_values[i];
		end
		return acc;
	endfunction

	task automatic check_value(input string label, input logic [EDGE_DATA_W-1:0] expected,
		input logic [EDGE_DATA_W-1:0] actual);
		check_count++;
		if (expected !== actual) begin
			$display("ERR %s: expected %0h, actual %0h", label, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_failure(input string text);
		$display("%s", text);
		error_count++;
		test_errors++;
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (test_errors == 0) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d errors", name, test_errors);
		end
	endtask

	task automatic start_job(input logic [VERTEX_ID_W-1:0] id, input int degree);
		@(posedge clock);
		#1;
		job_valid  = 1'b1;
		job_id     = id;
		job_degree = DEGREE_W'(degree);
	endtask

	// Back-to-back pushes of the staged values
	task automatic push_stim_edges();
		foreach (stim_values[i]) begin
			@(posedge clock);
			#1;
			edge_push  = 1'b1;
			edge_value = stim_values[i];
			total_edges++;
		end
		@(posedge clock);
		#1;
		edge_push = 1'b0;
	endtask

	task automatic send_response();
		@(posedge clock);
		#1;
		write_response = 1'b1;
		@(posedge clock);
		#1;
		write_response = 1'b0;
		responses_sent++;
	endtask

	task automatic wait_edge_count(input string test, input int target);
		int waited;
		waited = 0;
		while (edge_count != EDGE_DATA_W'(target) && waited < EVENT_TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		if (edge_count != EDGE_DATA_W'(target)) begin
			report_failure($sformatf("%s: edge count stuck at %0d, waiting for %0d",
				test, edge_count, target));
		end
	endtask

	// Wait for the next record, check it, then answer it
	task automatic expect_record(input string test, input logic [VERTEX_ID_W-1:0] id,
		input logic [EDGE_DATA_W-1:0] sum);
		logic [VERTEX_ID_W-1:0] rec_id;
		logic [CU_ID_W-1:0]     rec_cu;
		logic [EDGE_DATA_W-1:0] rec_data;
		int                     waited;
		waited = 0;
		while (rec_q.size() == 0 && waited < EVENT_TIMEOUT) begin
			@(posedge clock);
			waited++;
		end
		if (rec_q.size() == 0) begin
			report_failure($sformatf("%s: no write record for vertex %0h within %0d cycles",
				test, id, EVENT_TIMEOUT));
		end else begin
			{rec_id, rec_cu, rec_data} = rec_q.pop_front();
			check_value({test, " index"}, EDGE_DATA_W'(id), EDGE_DATA_W'(rec_id));
			check_value({test, " cu_id"}, EDGE_DATA_W'(TB_CU_ID), EDGE_DATA_W'(rec_cu));
			check_value({test, " sum"}, sum, rec_data);
			send_response();
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic test_single_vertex();
		test_errors = 0;
		stim_values.delete();
		// Total crosses 2^32 on purpose
		stim_values.push_back(32'hFFFF_FFF0);
		stim_values.push_back(32'h0000_0020);
		stim_values.push_back(32'h1234_5678);
		stim_values.push_back(32'h8000_0001);
		start_job(16'h0011, 4);
		push_stim_edges();
		expect_record("single_vertex", 16'h0011, model_sum());
		finish_test("single_vertex");
	endtask

	task automatic test_sequential_vertices();
		int degree;
		test_errors = 0;
		for (int j = 0; j < 5; j++) begin
			rng_state = xorshift32(rng_state);
			degree = 1 + int'(rng_state % 32'd8);
			fill_random_values(degree);
			start_job(VERTEX_ID_W'(32'h100 + j), degree);
			push_stim_edges();
			expect_record("sequential", VERTEX_ID_W'(32'h100 + j), model_sum());
		end
		finish_test("sequential");
	endtask

	task automatic test_enable_low();
		logic [EDGE_DATA_W-1:0] count_before;
		logic [EDGE_DATA_W-1:0] expected;
		test_errors = 0;
		@(posedge clock);
		#1;
		enable = 1'b0;
		repeat (2) @(posedge clock);
		#1;
		count_before = edge_count;
		fill_random_values(DEFAULT_EDGE_DEPTH);
		expected = model_sum();
		start_job(16'h0200, DEFAULT_EDGE_DEPTH);
		push_stim_edges();
		// Edges fill the input buffer
		repeat (10) @(posedge clock);
		#1;
		check_value("enable_low writes", '0, EDGE_DATA_W'(rec_q.size()));
		check_value("enable_low edge_count", count_before, edge_count);
		check_value("enable_low edge_full", EDGE_DATA_W'(1), EDGE_DATA_W'(edge_full));
		enable = 1'b1;
		expect_record("enable_low", 16'h0200, expected);
		check_value("enable_low edge_count after",
			count_before + EDGE_DATA_W'(DEFAULT_EDGE_DEPTH), edge_count);
		check_value("enable_low edge_full after", '0, EDGE_DATA_W'(edge_full));
		finish_test("enable_low");
	endtask

	task automatic test_back_pressure();
		logic [EDGE_DATA_W-1:0] sums[3];
		test_errors = 0;
		@(posedge clock);
		#1;
		write_alfull = 1'b1;
		for (int k = 0; k < 3; k++) begin
			fill_random_values(3 + k);
			sums[k] = model_sum();
			start_job(VERTEX_ID_W'(32'h300 + k), 3 + k);
			push_stim_edges();
			// Record enters the write FIFO right after the last edge
			wait_edge_count("back_pressure", total_edges);
			repeat (2) @(posedge clock);
		end
		repeat (5) @(posedge clock);
		#1;
		check_value("back_pressure held writes", '0, EDGE_DATA_W'(rec_q.size()));
		write_alfull = 1'b0;
		for (int k = 0; k < 3; k++) begin
			expect_record("back_pressure", VERTEX_ID_W'(32'h300 + k), sums[k]);
		end
		finish_test("back_pressure");
	endtask

	task automatic test_counters();
		test_errors = 0;
		@(posedge clock);
		#1;
		check_value("counters edge_count", EDGE_DATA_W'(total_edges), edge_count);
		check_value("counters response_count", EDGE_DATA_W'(responses_sent),
			EDGE_DATA_W'(response_count));
		finish_test("counters");
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		error_count    = 0;
		test_errors    = 0;
		check_count    = 0;
		test_count     = 0;
		total_edges    = 0;
		responses_sent = 0;
		rstn           = 1'b0;
		edge_push      = 1'b0;
		edge_value     = '0;
		job_valid      = 1'b0;
		job_id         = '0;
		job_degree     = '0;
		enable         = 1'b0;
		write_alfull   = 1'b0;
		write_response = 1'b0;
		repeat (2) @(posedge clock);
		#1;
		rstn   = 1'b1;
		enable = 1'b1;
		test_single_vertex();
		test_sequential_vertices();
		test_enable_low();
		test_back_pressure();
		test_counters();
		$display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/sum_cu_assert.sv
// Compute unit protocol checks
`timescale 1ns/1ns
`default_nettype none

module sum_cu_assert (
	input logic clock,
	input logic rstn,
	input logic edge_pop,
	input logic edge_empty,
	input logic edge_valid,
	input logic write_valid,
	input logic write_alfull
);

	////////////////////
	// Write side
	////////////////////

	// Drain decision, then FIFO read, then output register
	a_write_after_release: assert property (
		@(posedge clock) disable iff (!rstn)
		write_valid |-> !$past(write_alfull, 2)
	) else $error("write_valid with write_alfull high two cycles before");

	a_write_valid_known: assert property (
		@(posedge clock) disable iff (!rstn)
		!$isunknown(write_valid)
	) else $error("write_valid unknown after reset");

	////////////////////
	// Edge side
	////////////////////

	// Every accepted pop returns a stored edge one cycle later
	a_pop_returns_edge: assert property (
		@(posedge clock) disable iff (!rstn)
		(edge_pop && !edge_empty) |=> edge_valid
	) else $error("accepted edge pop without a valid edge one cycle later");

endmodule

bind sum_cu_top sum_cu_assert i_assert (
	.clock       (clock),
	.rstn        (rstn),
	.edge_pop    (edge_bus.pop),
	.edge_empty  (edge_bus.empty),
	.edge_valid  (edge_bus.valid),
	.write_valid (write_valid),
	.write_alfull(write_alfull)
);

`default_nettype wire

//--- rtl/sum_cu_top.sv
// Summing compute unit top
`timescale 1ns/1ns
`default_nettype none

module sum_cu_top import cu_config_pkg::*, graph_types_pkg::*; #(
	parameter int CU_ID       = 1,
	parameter int EDGE_DEPTH  = DEFAULT_EDGE_DEPTH,
	parameter int WRITE_DEPTH = DEFAULT_WRITE_DEPTH
) (
	input  logic                   clock,
	input  logic                   rstn,

	// Edge input
	input  logic                   edge_push,
	input  logic [EDGE_DATA_W-1:0] edge_value,
	output logic                   edge_full,

	// Vertex job, held until its record leaves
	input  logic                   job_valid,
	input  logic [VERTEX_ID_W-1:0] job_id,
	input  logic [DEGREE_W-1:0]    job_degree,

	input  logic                   enable,

	// Write record out
	output logic                   write_valid,
	output logic [VERTEX_ID_W-1:0] write_index,
	output logic [CU_ID_W-1:0]     write_cu_id,
	output logic [EDGE_DATA_W-1:0] write_data,
	input  logic                   write_alfull,
	input  logic                   write_response,

	// Status counters
	output logic [EDGE_DATA_W-1:0] edge_count,
	output logic [VERTEX_ID_W-1:0] response_count
);

	edge_read_if edge_bus ();

	edge_read_t  edge_word_in;
	edge_read_t  edge_word_out;
	logic        edge_pop_valid;
	vertex_job_t job;
	edge_write_t write_record;

	////////////////////
	// Edge input buffer
	////////////////////

	assign edge_word_in = '{valid: 1'b1, data: edge_value};

	sync_fifo #(
		.payload_t(edge_read_t),
		.DEPTH    (EDGE_DEPTH)
	) i_edge_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (edge_push),
		.data_in (edge_word_in),
		.full    (edge_full),
		.alfull  (),
		.pop     (edge_bus.pop),
		.valid   (edge_pop_valid),
		.data_out(edge_word_out),
		.empty   (edge_bus.empty)
	);

	// Buffer side of the link
	assign edge_bus.valid = edge_pop_valid & edge_word_out.valid;
	assign edge_bus.data  = edge_word_out.data;

	////////////////////
	// Kernel
	////////////////////

	assign job = '{valid: job_valid, id: job_id, degree: job_degree};

	sum_kernel_control #(
		.CU_ID      (CU_ID),
		.WRITE_DEPTH(WRITE_DEPTH)
	) i_kernel (
		.clock         (clock),
		.rstn          (rstn),
		.enable        (enable),
		.job           (job),
		.edge_in       (edge_bus.consumer),
		.write_alfull  (write_alfull),
		.write_response(write_response),
		.write_record  (write_record),
		.edge_count    (edge_count),
		.response_count(response_count)
	);

	// Record fields out to plain ports
	assign write_valid = write_record.valid;
	assign write_index = write_record.index;
	assign write_cu_id = write_record.cu_id;
	assign write_data  = write_record.data;

endmodule

`default_nettype wire

//--- rtl/sum_kernel_control.sv
// Summing kernel control
`timescale 1ns/1ns
`default_nettype none

module sum_kernel_control import cu_config_pkg::*, graph_types_pkg::*; #(
	parameter int CU_ID       = 1,
	parameter int WRITE_DEPTH = 16
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enable,
	input  vertex_job_t            job,
	edge_read_if.consumer          edge_in,
	input  logic                   write_alfull,
	input  logic                   write_response,
	output edge_write_t            write_record,
	output logic [EDGE_DATA_W-1:0] edge_count,
	output logic [VERTEX_ID_W-1:0] response_count
);

	logic                   enabled;
	vertex_job_t            job_q;
	edge_read_t             edge_q;
	logic [EDGE_DATA_W-1:0] sum;
	logic [DEGREE_W-1:0]    sum_count;
	logic                   job_done;
	edge_write_t            done_record;
	logic                   wbuf_full;
	logic                   wbuf_alfull;
	logic                   wbuf_empty;
	logic                   wbuf_pop;
	logic                   wbuf_valid;
	edge_write_t            wbuf_data;

	////////////////////
	// Enable and job
	////////////////////

	// Enable acts one cycle late
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enable;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_q <= '0;
		end else if (enabled) begin
			job_q <= job;
		end
	end

	////////////////////
	// Edge pop and latch
	////////////////////

	// Raw enable too, so a popped edge never lands while disabled
	// Stop draining edges once the record buffer is nearly full
	assign edge_in.pop = enable & enabled & ~edge_in.empty & ~wbuf_alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_q <= '0;
		end else if (enabled) begin
			edge_q.valid <= edge_in.valid;
			edge_q.data  <= edge_in.data;
		end
	end

	////////////////////
	// Accumulate
	////////////////////

	assign job_done = enabled & job_q.valid & (sum_count == job_q.degree);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sum       <= '0;
			sum_count <= '0;
		end else if (enabled) begin
			if (job_done) begin
				// Edge landing on the finish cycle opens the next sum
				sum       <= edge_q.valid ? edge_q.data : '0;
				sum_count <= edge_q.valid ? DEGREE_W'(1) : '0;
			end else if (edge_q.valid) begin
				// Wraps modulo 2^EDGE_DATA_W
				sum       <= sum + edge_q.data;
				sum_count <= sum_count + 1'b1;
			end
		end
	end

	// Finished sum, tagged with vertex and unit
	assign done_record = '{
		valid: 1'b1,
		index: job_q.id,
		cu_id: CU_ID_W'(CU_ID),
		data:  sum
	};

	////////////////////
	// Record buffer
	////////////////////

	// Drain only while the downstream is not almost full
	assign wbuf_pop = enabled & ~wbuf_empty & ~write_alfull;

	sync_fifo #(
		.payload_t(edge_write_t),
		.DEPTH    (WRITE_DEPTH)
	) i_write_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_done & ~wbuf_full),
		.data_in (done_record),
		.full    (wbuf_full),
		.alfull  (wbuf_alfull),
		.pop     (wbuf_pop),
		.valid   (wbuf_valid),
		.data_out(wbuf_data),
		.empty   (wbuf_empty)
	);

	// Extra output stage, valid is a one-cycle strobe
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_record <= '0;
		end else begin
			write_record       <= wbuf_data;
			write_record.valid <= wbuf_valid & wbuf_data.valid;
		end
	end

	////////////////////
	// Counters
	////////////////////

	// Edges actually summed
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_count <= '0;
		end else if (enabled && edge_q.valid) begin
			edge_count <= edge_count + 1'b1;
		end
	end

	// Responses come from outside, so counted even while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_count <= '0;
		end else if (write_response) begin
			response_count <= response_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/sync_fifo.sv
// Synchronous FIFO
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 16
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t data_in,
	output logic     full,
	output logic     alfull,
	input  logic     pop,
	output logic     valid,
	output payload_t data_out,
	output logic     empty
);

	localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_W = $clog2(DEPTH + 1);

	payload_t           mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [COUNT_W-1:0] count;
	logic               do_push;
	logic               do_pop;

	////////////////////
	// Status
	////////////////////

	assign full   = (count == COUNT_W'(DEPTH));
	// One free slot or fewer
	assign alfull = (count >= COUNT_W'(DEPTH - 1));
	assign empty  = (count == '0);

	// Overflow and underflow are dropped here
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	////////////////////
	// Pointers and count
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				// Wrap at DEPTH, not at the pointer width
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	////////////////////
	// Registered read
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			valid <= 1'b0;
		end else begin
			// One strobe per accepted pop
			valid <= do_pop;
		end
	end

	// Output word holds until the next pop
	always_ff @(posedge clock) begin
		if (do_pop) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

//--- rtl/edge_read_if.sv
// Edge buffer to kernel link
`timescale 1ns/1ns
`default_nettype none

interface edge_read_if import cu_config_pkg::*; ();

	// Level from the kernel, one value per cycle while high
	logic                   pop;
	// Popped value shows up one cycle after pop
	logic                   valid;
	logic [EDGE_DATA_W-1:0] data;
	// Buffer status, acts as the request
	logic                   empty;

	// Input buffer side
	modport buffer (
		input  pop,
		output valid, data, empty
	);

	// Kernel side
	modport consumer (
		output pop,
		input  valid, data, empty
	);

endinterface

`default_nettype wire

//--- rtl/graph_types_pkg.sv
// Graph job and edge records
`default_nettype none

package graph_types_pkg;

	import cu_config_pkg::*;

	////////////////////
	// Vertex job
	////////////////////

	// Held by the environment until the record leaves
	typedef struct packed {
		logic                   valid;
		logic [VERTEX_ID_W-1:0] id;
		logic [DEGREE_W-1:0]    degree;
	} vertex_job_t;

	////////////////////
	// Edge traffic
	////////////////////

	// One edge value out of the input buffer
	typedef struct packed {
		logic                   valid;
		logic [EDGE_DATA_W-1:0] data;
	} edge_read_t;

	// Finished sum for one vertex
	typedef struct packed {
		logic                   valid;
		logic [VERTEX_ID_W-1:0] index;
		logic [CU_ID_W-1:0]     cu_id;
		logic [EDGE_DATA_W-1:0] data;
	} edge_write_t;

endpackage

`default_nettype wire

//--- rtl/cu_config_pkg.sv
// Compute unit configuration
`default_nettype none

package cu_config_pkg;

	////////////////////
	// Field widths
	////////////////////

	// Vertex index
	localparam int VERTEX_ID_W = 16;
	// In-degree of one vertex
	localparam int DEGREE_W    = 16;
	// Edge value, also the sum
	localparam int EDGE_DATA_W = 32;
	// Compute unit number
	localparam int CU_ID_W     = 4;

	////////////////////
	// Buffer sizes
	////////////////////

	localparam int DEFAULT_EDGE_DEPTH  = 16;
	localparam int DEFAULT_WRITE_DEPTH = 16;

endpackage

`default_nettype wire
